// File: hdl/pi1_pkg.sv
////////////////////
// PI1 bus package
////////////////////

package pi1_pkg;

	localparam int ARCH_BITS        = 32;
	localparam int ADDR_BITS        = 30;
	localparam int SEL_BITS         = 4;
	localparam int MASTER_COUNT     = 2;
	localparam int SLAVE_COUNT      = 2;
	localparam int MASTER_IDX_BITS  = 1;
	localparam int SLAVE_IDX_BITS   = 1;
	localparam int DEFAULT_SLAVE    = 0;
	localparam int FIRST_SLAVE_ADDR = 0;
	localparam int RAM0_WORDS       = 256;
	localparam int RAM1_WORDS       = 64;

	typedef enum logic [1:0] {
		PI_NOOP = 2'b00,
		PI_WROP = 2'b01,
		PI_RDOP = 2'b10,
		PI_RWOP = 2'b11
	} pi1_op_t;

	typedef logic [ADDR_BITS - 1:0]       pi1_addr_t;
	typedef logic [ARCH_BITS - 1:0]       pi1_data_t;
	typedef logic [SEL_BITS - 1:0]        pi1_sel_t;
	typedef logic [MASTER_IDX_BITS - 1:0] master_idx_t;
	typedef logic [SLAVE_IDX_BITS - 1:0]  slave_idx_t;

	typedef enum logic [1:0] {
		MAP_BUILD,
		MAP_LOOKUP,
		MAP_READY
	} map_state_t;

	// Words claimed by each slave, in map order from FIRST_SLAVE_ADDR.
	localparam pi1_addr_t SLAVE_MAP_SIZE [SLAVE_COUNT] = '{
		pi1_addr_t'(RAM0_WORDS),
		pi1_addr_t'(RAM1_WORDS)
	};

endpackage

// File: hdl/pi1_arbiter.sv
////////////////////
// Master arbiter
////////////////////

module pi1_arbiter import pi1_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_i,
	input  pi1_op_t     m_op_i [MASTER_COUNT],
	input  logic        grant_rdy_i,
	output master_idx_t grant_o
);

	master_idx_t grant_q;
	master_idx_t hi_q;      // Wrap point of the current round.
	master_idx_t hi_next_q;
	master_idx_t scan_q;

	// Walk down from the top master to find the highest one with a request.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			scan_q    <= master_idx_t'(MASTER_COUNT - 1);
			hi_next_q <= master_idx_t'(MASTER_COUNT - 1);
		end else if (scan_q == '0 || m_op_i[scan_q] != PI_NOOP) begin
			if (m_op_i[scan_q] != PI_NOOP)
				hi_next_q <= scan_q;
			scan_q <= master_idx_t'(MASTER_COUNT - 1);
		end else begin
			scan_q <= scan_q - 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			grant_q <= '0;
			hi_q    <= master_idx_t'(MASTER_COUNT - 1);
		end else if (grant_rdy_i && m_op_i[grant_q] == PI_NOOP) begin
			if (grant_q < hi_q) begin
				grant_q <= grant_q + 1'b1;
			end else begin
				grant_q <= '0;
				hi_q    <= hi_next_q; // Idle top masters drop out of the next round.
			end
		end
	end

	assign grant_o = grant_q;

endmodule

// File: hdl/pi1_addr_decoder.sv
////////////////////
// Address decoder
////////////////////

module pi1_addr_decoder import pi1_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	input  pi1_op_t    op_i,
	input  pi1_addr_t  addr_i,
	output slave_idx_t slave_o,
	output pi1_addr_t  slave_addr_o,
	output logic       hit_o
);

	map_state_t state_q;
	slave_idx_t slave_q;
	pi1_addr_t  base_q;                  // First word of slave_q, or the folded address.
	logic       fold_q;
	pi1_addr_t  last_addr [SLAVE_COUNT];
	logic       in_range;
	logic       miss;

	assign in_range = fold_q ? (addr_i == base_q)
		: (addr_i >= base_q && addr_i <= last_addr[slave_q]);
	assign miss = (op_i != PI_NOOP) && !in_range;

	assign hit_o   = (state_q == MAP_READY) && !miss;
	assign slave_o = slave_q;
	assign slave_addr_o = fold_q ? pi1_addr_t'(addr_i % pi1_addr_t'(RAM0_WORDS))
		: addr_i - base_q;

	always_ff @(posedge clk_i) begin
		if (state_q == MAP_BUILD)
			last_addr[slave_q] <= base_q + SLAVE_MAP_SIZE[slave_q] - 1'b1;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= MAP_BUILD;
			slave_q <= '0;
			base_q  <= pi1_addr_t'(FIRST_SLAVE_ADDR);
			fold_q  <= 1'b0;
		end else begin
			case (state_q)
				MAP_BUILD: begin
					if (slave_q != slave_idx_t'(SLAVE_COUNT - 1)) begin
						base_q  <= base_q + SLAVE_MAP_SIZE[slave_q];
						slave_q <= slave_q + 1'b1;
					end else begin
						base_q  <= pi1_addr_t'(FIRST_SLAVE_ADDR);
						slave_q <= '0;
						state_q <= MAP_LOOKUP;
					end
				end
				MAP_LOOKUP: begin
					if (!miss) begin
						state_q <= MAP_READY;
					end else if (slave_q != slave_idx_t'(SLAVE_COUNT - 1)) begin
						base_q  <= last_addr[slave_q] + 1'b1;
						slave_q <= slave_q + 1'b1;
					end else begin
						// Nothing claims the address, so the default slave takes it.
						base_q  <= addr_i;
						slave_q <= slave_idx_t'(DEFAULT_SLAVE);
						fold_q  <= 1'b1;
						state_q <= MAP_READY;
					end
				end
				default: begin
					if (miss) begin
						base_q  <= pi1_addr_t'(FIRST_SLAVE_ADDR);
						slave_q <= '0;
						fold_q  <= 1'b0;
						state_q <= MAP_LOOKUP;
					end
				end
			endcase
		end
	end

endmodule

// File: hdl/pi1_interconnect.sv
////////////////////
// PI1 interconnect
////////////////////

module pi1_interconnect import pi1_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_i,
	input  pi1_op_t   m_op_i   [MASTER_COUNT],
	input  pi1_addr_t m_addr_i [MASTER_COUNT],
	input  pi1_data_t m_data_i [MASTER_COUNT],
	input  pi1_sel_t  m_sel_i  [MASTER_COUNT],
	output pi1_data_t m_data_o [MASTER_COUNT],
	output logic      m_rdy_o  [MASTER_COUNT],
	output pi1_op_t   s_op_o   [SLAVE_COUNT],
	output pi1_addr_t s_addr_o [SLAVE_COUNT],
	output pi1_data_t s_data_o [SLAVE_COUNT],
	output pi1_sel_t  s_sel_o  [SLAVE_COUNT],
	input  pi1_data_t s_data_i [SLAVE_COUNT],
	input  logic      s_rdy_i  [SLAVE_COUNT]
);

	master_idx_t grant;
	slave_idx_t  slave_sel;
	pi1_addr_t   slave_addr;
	logic        hit;
	logic        grant_rdy;
	logic        pend_q;       // A read is waiting for its slave.
	slave_idx_t  pend_slave_q;
	pi1_data_t   rdata_q;
	logic        pend_done;
	logic        read_acc;

	pi1_arbiter u_arbiter (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.m_op_i      (m_op_i),
		.grant_rdy_i (grant_rdy),
		.grant_o     (grant)
	);

	pi1_addr_decoder u_decoder (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.op_i         (m_op_i[grant]),
		.addr_i       (m_addr_i[grant]),
		.slave_o      (slave_sel),
		.slave_addr_o (slave_addr),
		.hit_o        (hit)
	);

	assign pend_done = pend_q && s_rdy_i[pend_slave_q];
	assign grant_rdy = (pend_done || !pend_q) && hit && s_rdy_i[slave_sel];
	assign read_acc  = grant_rdy && (m_op_i[grant] == PI_RDOP || m_op_i[grant] == PI_RWOP);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pend_q       <= 1'b0;
			pend_slave_q <= '0;
		end else if (pend_done) begin
			rdata_q <= s_data_i[pend_slave_q];
			if (read_acc)
				pend_slave_q <= slave_sel; // Back-to-back read keeps the flag set.
			else
				pend_q <= 1'b0;
		end else if (read_acc) begin
			pend_slave_q <= slave_sel;
			pend_q       <= 1'b1;
		end
	end

	always_comb begin
		for (int i = 0; i < MASTER_COUNT; i++) begin
			m_rdy_o[i]  = (grant == master_idx_t'(i)) && grant_rdy;
			m_data_o[i] = pend_done ? s_data_i[pend_slave_q] : rdata_q;
		end
		for (int i = 0; i < SLAVE_COUNT; i++) begin
			s_op_o[i]   = (slave_sel == slave_idx_t'(i) && grant_rdy) ? m_op_i[grant] : PI_NOOP;
			s_addr_o[i] = slave_addr;
			s_data_o[i] = m_data_i[grant];
			s_sel_o[i]  = m_sel_i[grant];
		end
	end

endmodule

// File: hdl/pi1_ram.sv
////////////////////
// RAM slave
////////////////////

module pi1_ram import pi1_pkg::*; #(
	parameter int DEPTH       = 256,
	parameter int WAIT_CYCLES = 1
) (
	input  logic      clk_i,
	input  logic      rst_i,
	input  pi1_op_t   op_i,
	input  pi1_addr_t addr_i,
	input  pi1_data_t data_i,
	input  pi1_sel_t  sel_i,
	output pi1_data_t data_o,
	output logic      rdy_o
);

	typedef logic [$clog2(DEPTH) - 1:0]           ram_idx_t;
	typedef logic [$clog2(WAIT_CYCLES + 2) - 1:0] wait_t;

	pi1_data_t mem [DEPTH];
	ram_idx_t  idx;
	wait_t     wait_q;

	assign idx   = ram_idx_t'(addr_i); // Upper address bits wrap onto the array.
	assign rdy_o = (wait_q == '0);

	always_ff @(posedge clk_i) begin
		if (rst_i)
			wait_q <= '0;
		else if (op_i != PI_NOOP)
			wait_q <= wait_t'(WAIT_CYCLES);
		else if (wait_q != '0)
			wait_q <= wait_q - 1'b1;
	end

	always_ff @(posedge clk_i) begin
		if (op_i == PI_RDOP || op_i == PI_RWOP)
			data_o <= mem[idx]; // Read-write returns the old word.
		if (op_i == PI_WROP || op_i == PI_RWOP) begin
			for (int b = 0; b < SEL_BITS; b++) begin
				if (sel_i[b])
					mem[idx][b * 8 +: 8] <= data_i[b * 8 +: 8];
			end
		end
	end

endmodule

// File: hdl/pi1_system.sv
////////////////////
// Memory system top
////////////////////

module pi1_system import pi1_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_i,
	input  pi1_op_t   m_op_i   [MASTER_COUNT],
	input  pi1_addr_t m_addr_i [MASTER_COUNT],
	input  pi1_data_t m_data_i [MASTER_COUNT],
	input  pi1_sel_t  m_sel_i  [MASTER_COUNT],
	output pi1_data_t m_data_o [MASTER_COUNT],
	output logic      m_rdy_o  [MASTER_COUNT]
);

	pi1_op_t   s_op   [SLAVE_COUNT];
	pi1_addr_t s_addr [SLAVE_COUNT];
	pi1_data_t s_wdata [SLAVE_COUNT];
	pi1_sel_t  s_sel  [SLAVE_COUNT];
	pi1_data_t s_rdata [SLAVE_COUNT];
	logic      s_rdy  [SLAVE_COUNT];

	pi1_interconnect u_interconnect (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.m_op_i   (m_op_i),
		.m_addr_i (m_addr_i),
		.m_data_i (m_data_i),
		.m_sel_i  (m_sel_i),
		.m_data_o (m_data_o),
		.m_rdy_o  (m_rdy_o),
		.s_op_o   (s_op),
		.s_addr_o (s_addr),
		.s_data_o (s_wdata),
		.s_sel_o  (s_sel),
		.s_data_i (s_rdata),
		.s_rdy_i  (s_rdy)
	);

	pi1_ram #(.DEPTH(RAM0_WORDS), .WAIT_CYCLES(1)) u_ram0 (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.op_i   (s_op[0]),
		.addr_i (s_addr[0]),
		.data_i (s_wdata[0]),
		.sel_i  (s_sel[0]),
		.data_o (s_rdata[0]),
		.rdy_o  (s_rdy[0])
	);

	pi1_ram #(.DEPTH(RAM1_WORDS), .WAIT_CYCLES(2)) u_ram1 (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.op_i   (s_op[1]),
		.addr_i (s_addr[1]),
		.data_i (s_wdata[1]),
		.sel_i  (s_sel[1]),
		.data_o (s_rdata[1]),
		.rdy_o  (s_rdy[1])
	);

endmodule

// File: tests/tb_clock_gen.sv
////////////////////
// Clock and reset
////////////////////

module tb_clock_gen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 5
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0; // Released on a rising edge, like a synchronous reset.
	end

endmodule

// File: tests/tb_pi1_system.sv
////////////////////
// PI1 system testbench
////////////////////

module tb_pi1_system import pi1_pkg::*; ();

	localparam int MAP_WORDS      = RAM0_WORDS + RAM1_WORDS;
	localparam int RAND_OPS       = 40;
	localparam int ACCESS_COUNT   = 36 + 12 + 4 + 5 + MASTER_COUNT * RAND_OPS;
	localparam int ACCESS_CYCLES  = 30; // Lookup, slave wait and the other master's turn.
	localparam int TIMEOUT_CYCLES = ACCESS_COUNT * ACCESS_CYCLES + 200;

	logic      clk;
	logic      rst;
	pi1_op_t   m_op    [MASTER_COUNT];
	pi1_addr_t m_addr  [MASTER_COUNT];
	pi1_data_t m_wdata [MASTER_COUNT];
	pi1_sel_t  m_sel   [MASTER_COUNT];
	pi1_data_t m_rdata [MASTER_COUNT];
	logic      m_rdy   [MASTER_COUNT];

	pi1_data_t ref_mem [MAP_WORDS];
	pi1_data_t exp_q [$];
	pi1_data_t got_q [$];
	string     tag_q [$];
	pi1_op_t   rand_op   [MASTER_COUNT][RAND_OPS];
	pi1_addr_t rand_addr [MASTER_COUNT][RAND_OPS];
	pi1_data_t rand_data [MASTER_COUNT][RAND_OPS];
	pi1_sel_t  rand_sel  [MASTER_COUNT][RAND_OPS];
	integer    seed = 86;
	string     test_name = "reset";
	int        check_count = 0;
	int        error_count = 0;
	int        test_checks = 0;
	int        test_errors = 0;
	int        cycle_count = 0;

	tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(5)) u_clock_gen (
		.clk_o (clk),
		.rst_o (rst)
	);

	pi1_system uut (
		.clk_i    (clk),
		.rst_i    (rst),
		.m_op_i   (m_op),
		.m_addr_i (m_addr),
		.m_data_i (m_wdata),
		.m_sel_i  (m_sel),
		.m_data_o (m_rdata),
		.m_rdy_o  (m_rdy)
	);

	// Unmapped words fold onto RAM0.
	function automatic int word_index(input pi1_addr_t addr);
		if (addr - FIRST_SLAVE_ADDR < MAP_WORDS)
			return int'(addr - FIRST_SLAVE_ADDR);
		return int'(addr % RAM0_WORDS);
	endfunction

	function automatic pi1_data_t merge_bytes(input pi1_data_t old, input pi1_data_t data,
			input pi1_sel_t sel);
		pi1_data_t res;
		res = old;
		for (int b = 0; b < SEL_BITS; b++) begin
			if (sel[b])
				res[b * 8 +: 8] = data[b * 8 +: 8];
		end
		return res;
	endfunction

	// Returns the word a read sees and applies any write to the model.
	function automatic pi1_data_t model_access(input pi1_op_t op, input pi1_addr_t addr,
			input pi1_data_t data, input pi1_sel_t sel);
		int        idx;
		pi1_data_t old;
		idx = word_index(addr);
		old = ref_mem[idx];
		if (op == PI_WROP || op == PI_RWOP)
			ref_mem[idx] = merge_bytes(old, data, sel);
		return old;
	endfunction

	// Holds one request until its rdy pulse; called just after a rising edge.
	task automatic transfer(input int m, input pi1_op_t op, input pi1_addr_t addr,
			input pi1_data_t data, input pi1_sel_t sel, output pi1_data_t rdata);
		m_op[m]    <= op;
		m_addr[m]  <= addr;
		m_wdata[m] <= data;
		m_sel[m]   <= sel;
		do
			@(negedge clk);
		while (!m_rdy[m]);
		rdata = m_rdata[m];
		@(posedge clk);
	endtask

	task automatic access(input int m, input pi1_op_t op, input pi1_addr_t addr,
			input pi1_data_t data, input pi1_sel_t sel);
		pi1_data_t expected;
		pi1_data_t rdata;
		transfer(m, op, addr, data, sel, rdata);
		expected = model_access(op, addr, data, sel);
		transfer(m, PI_NOOP, addr, '0, '0, rdata); // Read data arrives with this pulse.
		if (op == PI_RDOP || op == PI_RWOP) begin
			tag_q.push_back($sformatf("%s m%0d addr %0h", test_name, m, addr));
			exp_q.push_back(expected);
			got_q.push_back(rdata);
		end
	endtask

	task automatic report_test();
		repeat (2) @(posedge clk);
		$display("%s: %0d checks, %0d errors", test_name, check_count - test_checks,
			error_count - test_errors);
		test_checks = check_count;
		test_errors = error_count;
	endtask

	always @(posedge clk) begin
		while (exp_q.size() > 0) begin
			check_count++;
			assert (got_q[0] === exp_q[0]) else begin
				$display("** Error: %s expected %h actual %h", tag_q[0], exp_q[0], got_q[0]);
				error_count++;
			end
			void'(exp_q.pop_front());
			void'(got_q.pop_front());
			void'(tag_q.pop_front());
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles while a master waited for its handshake.",
				cycle_count);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		pi1_addr_t addr_list [$];
		int        k;
		for (int m = 0; m < MASTER_COUNT; m++) begin
			m_op[m]    <= PI_NOOP;
			m_addr[m]  <= '0;
			m_wdata[m] <= '0;
			m_sel[m]   <= '0;
		end
		wait (!rst);
		@(posedge clk);

		test_name = "full_word";
		for (int i = 0; i < 8; i++) begin
			addr_list.push_back(pi1_addr_t'(i));
			addr_list.push_back(pi1_addr_t'(RAM0_WORDS + i));
		end
		addr_list.push_back(pi1_addr_t'(RAM0_WORDS - 1)); // Boundary words of both slaves.
		addr_list.push_back(pi1_addr_t'(MAP_WORDS - 1));
		foreach (addr_list[i])
			access(0, PI_WROP, addr_list[i], pi1_data_t'($random(seed)), '1);
		foreach (addr_list[i])
			access(0, PI_RDOP, addr_list[i], '0, '0);
		report_test();

		test_name = "byte_select";
		for (int i = 0; i < 6; i++) begin
			k = (i < 3) ? i : RAM0_WORDS + i;
			access(0, PI_WROP, pi1_addr_t'(k), pi1_data_t'($random(seed)),
				pi1_sel_t'($random(seed)));
			access(0, PI_RDOP, pi1_addr_t'(k), '0, '0);
		end
		report_test();

		test_name = "read_write";
		access(0, PI_RWOP, pi1_addr_t'(5), pi1_data_t'($random(seed)), '1);
		access(0, PI_RWOP, pi1_addr_t'(RAM0_WORDS + 4), pi1_data_t'($random(seed)), 4'b0110);
		access(0, PI_RDOP, pi1_addr_t'(5), '0, '0);
		access(0, PI_RDOP, pi1_addr_t'(RAM0_WORDS + 4), '0, '0);
		report_test();

		test_name = "alias";
		access(0, PI_WROP, pi1_addr_t'(1000), pi1_data_t'($random(seed)), '1);
		access(0, PI_RDOP, pi1_addr_t'(232), '0, '0);
		access(0, PI_WROP, pi1_addr_t'(232), pi1_data_t'($random(seed)), '1);
		access(0, PI_RDOP, pi1_addr_t'(488), '0, '0);
		access(0, PI_RWOP, pi1_addr_t'(1023), pi1_data_t'($random(seed)), '1);
		report_test();

		// Stimulus is drawn up front so both masters see a fixed sequence.
		test_name = "random";
		for (int m = 0; m < MASTER_COUNT; m++) begin
			for (int i = 0; i < RAND_OPS; i++) begin
				case ($unsigned($random(seed)) % 3)
					0:       rand_op[m][i] = PI_WROP;
					1:       rand_op[m][i] = PI_RDOP;
					default: rand_op[m][i] = PI_RWOP;
				endcase
				k = $unsigned($random(seed)) % 8;
				case ($unsigned($random(seed)) % 3)
					0:       rand_addr[m][i] = pi1_addr_t'(k);
					1:       rand_addr[m][i] = pi1_addr_t'(RAM0_WORDS + k);
					default: rand_addr[m][i] = pi1_addr_t'(3 * RAM0_WORDS + k);
				endcase
				rand_data[m][i] = pi1_data_t'($random(seed));
				rand_sel[m][i]  = pi1_sel_t'($random(seed));
			end
		end
		fork
			for (int i = 0; i < RAND_OPS; i++)
				access(0, rand_op[0][i], rand_addr[0][i], rand_data[0][i], rand_sel[0][i]);
			for (int i = 0; i < RAND_OPS; i++)
				access(1, rand_op[1][i], rand_addr[1][i], rand_data[1][i], rand_sel[1][i]);
		join
		report_test();

		$display("Total: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0 && check_count > 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: pi1_system.f
hdl/pi1_pkg.sv
hdl/pi1_arbiter.sv
hdl/pi1_addr_decoder.sv
hdl/pi1_interconnect.sv
hdl/pi1_ram.sv
hdl/pi1_system.sv
tests/tb_clock_gen.sv
tests/tb_pi1_system.sv

// File: Bender.yml
package:
  name: pi1_system

sources:
  - hdl/pi1_pkg.sv
  - hdl/pi1_arbiter.sv
  - hdl/pi1_addr_decoder.sv
  - hdl/pi1_interconnect.sv
  - hdl/pi1_ram.sv
  - hdl/pi1_system.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_pi1_system.sv
